//--- hw/mxv_pkg.sv
// Shared widths, element types and APB address map of the 4x4 matrix-vector unit
// State encoding of the run controller

package mxv_pkg;

	// ============================================================
	// Dimensions and types
	// ============================================================
	localparam int N = 4;                       // Matrix dimension

	typedef logic [7:0]  data_t;                // Unsigned matrix or vector element
	typedef logic [17:0] acc_t;                 // Dot product, holds 4 * 255 * 255
	typedef logic [1:0]  idx_t;                 // Row or column index
	typedef logic [3:0]  mat_addr_t;            // Row * N + column
	typedef logic [7:0]  apb_addr_t;            // APB byte address

	// ============================================================
	// APB register map
	// ============================================================
	localparam apb_addr_t ADDR_CTRL   = 8'h00;  // W bit 0 starts a run
	localparam apb_addr_t ADDR_STATUS = 8'h04;  // R bit 0 busy, bit 1 done
	localparam apb_addr_t ADDR_VEC    = 8'h10;  // Vector, 0x10 to 0x1C
	localparam apb_addr_t ADDR_MAT    = 8'h40;  // Matrix row-major, 0x40 to 0x7C
	localparam apb_addr_t ADDR_RES    = 8'h80;  // Results, 0x80 to 0x8C

	// ============================================================
	// Run controller states
	// ============================================================
	typedef enum logic [1:0]
	{
		IDLE,                                   // Waiting for a start write
		RUN,                                    // PEs working, collecting done pulses
		FINISH                                  // All rows complete, raise done
	} ctrl_state_e;

endpackage

//--- hw/pe_if.sv
// pe_ctrl_if, start/done handshake between run controller and one PE
// mem_rd_if, request/grant read channel from one PE into the matrix bank

`timescale 1ns/1ps

interface pe_ctrl_if;
	import mxv_pkg::*;

	logic start;                                // One-cycle pulse from controller
	logic done;                                 // One-cycle pulse at end of row
	acc_t result;                               // Valid from done until next start

	modport ctrl
	(
		output start,
		input  done,
		input  result
	);

	modport pe
	(
		input  start,
		output done,
		output result
	);
endinterface

interface mem_rd_if;
	import mxv_pkg::*;

	logic      req;                             // Held with addr until gnt
	mat_addr_t addr;                            // Element wanted by the client
	logic      gnt;                             // Request accepted this cycle
	data_t     rdata;                           // Valid the cycle after gnt

	modport client
	(
		output req,
		output addr,
		input  gnt,
		input  rdata
	);

	modport bank
	(
		input  req,
		input  addr,
		output gnt,
		output rdata
	);
endinterface

//--- hw/mxv_apb_regs.sv
// APB slave for the matrix-vector unit
// Holds the vector and captured results, forwards matrix writes, raises run_start

`timescale 1ns/1ps

module mxv_apb_regs
(
	input  logic                clk,
	input  logic                rst,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  mxv_pkg::apb_addr_t  paddr,
	input  logic [31:0]         pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr,

	input  logic                busy,
	input  logic                done_flag,
	output logic                run_start,

	output mxv_pkg::data_t      vec [mxv_pkg::N],
	input  mxv_pkg::acc_t       res [mxv_pkg::N],
	input  logic [mxv_pkg::N-1:0] res_valid,

	output logic                mat_we,
	output mxv_pkg::mat_addr_t  mat_waddr,
	output mxv_pkg::data_t      mat_wdata
);

	import mxv_pkg::*;

	logic access;                               // APB access phase
	logic wr;                                   // Write in access phase
	logic wr_ok;                                // Write not blocked by a run
	logic aligned;                              // Word address
	logic is_ctrl;
	logic is_status;
	logic is_vec;
	logic is_mat;
	logic is_res;
	logic mapped;
	idx_t elem_idx;                             // Vector or result slot
	acc_t res_q [N];                            // Captured PE results

	// ============================================================
	// Address decode
	// ============================================================
	assign access    = psel & penable;
	assign wr        = access & pwrite;
	assign wr_ok     = wr & ~busy;
	assign aligned   = (paddr[1:0] == 2'b00);
	assign is_ctrl   = (paddr == ADDR_CTRL);
	assign is_status = (paddr == ADDR_STATUS);
	assign is_vec    = aligned & (paddr[7:4] == ADDR_VEC[7:4]);   // 0x10..0x1C
	assign is_mat    = aligned & (paddr[7:6] == ADDR_MAT[7:6]);   // 0x40..0x7C
	assign is_res    = aligned & (paddr[7:4] == ADDR_RES[7:4]);   // 0x80..0x8C
	assign mapped    = is_ctrl | is_status | is_vec | is_mat | is_res;
	assign elem_idx  = paddr[3:2];

	assign pready  = 1'b1;                      // No wait states
	assign pslverr = access & (~mapped | (pwrite & busy & (is_ctrl | is_vec | is_mat)));

	// Matrix writes go straight to the bank, only while idle
	assign mat_we    = wr_ok & is_mat;
	assign mat_waddr = paddr[5:2];
	assign mat_wdata = pwdata[7:0];

	// ============================================================
	// Registers
	// ============================================================
	always_ff @(posedge clk, negedge rst)
	begin : ctrl_regs
		if (!rst)
		begin
			run_start <= 1'b0;
			for (int i = 0; i < N; i++)
				res_q[i] <= '0;
		end
		else
		begin
			run_start <= wr_ok & is_ctrl & pwdata[0];           // Single-cycle pulse
			for (int i = 0; i < N; i++)
				if (res_valid[i])
					res_q[i] <= res[i];                         // Latch row on its done
		end
	end : ctrl_regs

	always_ff @(posedge clk)
	begin : vec_regs
		if (wr_ok && is_vec)
			vec[elem_idx] <= pwdata[7:0];                       // Broadcast to all PEs
	end : vec_regs

	// Read mux, zero-extended
	always_comb
	begin
		prdata = '0;
		if (is_status)
			prdata[1:0] = {done_flag, busy};
		else if (is_vec)
			prdata = 32'(vec[elem_idx]);
		else if (is_res)
			prdata = 32'(res_q[elem_idx]);
	end

endmodule

//--- hw/mxv_ctrl.sv
// Run controller, starts the four PEs and gathers their done pulses
// Drives busy and the sticky done flag seen by status and irq

`timescale 1ns/1ps

module mxv_ctrl
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    run_start,
	output logic                    busy,
	output logic                    done_flag,
	output logic [mxv_pkg::N-1:0]   res_valid,
	pe_ctrl_if.ctrl                 pe [mxv_pkg::N]
);

	import mxv_pkg::*;

	ctrl_state_e  state;
	logic         start_q;                      // Start pulse shared by all PEs
	logic [N-1:0] pe_done;                      // Done pulses this cycle
	logic [N-1:0] done_mask;                    // Rows finished so far

	for (genvar i = 0; i < N; i++)
	begin : g_pe
		assign pe[i].start = start_q;
		assign pe_done[i]  = pe[i].done;
	end

	assign res_valid = pe_done;                 // Result valid on its done cycle
	assign busy      = (state != IDLE);         // RUN and FINISH

	// ============================================================
	// State machine
	// ============================================================
	always_ff @(posedge clk, negedge rst)
	begin : fsm
		if (!rst)
		begin
			state     <= IDLE;
			start_q   <= 1'b0;
			done_mask <= '0;
			done_flag <= 1'b0;
		end
		else
		begin
			start_q <= 1'b0;
			case (state)
				IDLE:
				begin
					if (run_start)
					begin
						state     <= RUN;
						start_q   <= 1'b1;          // PEs see start in first RUN cycle
						done_mask <= '0;
						done_flag <= 1'b0;          // Clears irq
					end
				end

				RUN:
				begin
					done_mask <= done_mask | pe_done;
					if ((done_mask | pe_done) == {N{1'b1}})
						state <= FINISH;            // Every row reported
				end

				FINISH:
				begin
					done_flag <= 1'b1;
					state     <= IDLE;
				end

				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end : fsm

endmodule

//--- hw/mxv_pe.sv
// Processing element, multiply-accumulate over one matrix row
// Fetches each element through the arbitrated matrix bank port

`timescale 1ns/1ps

module mxv_pe
#(
	parameter mxv_pkg::idx_t ROW = '0           // Row this PE computes
)
(
	input  logic            clk,
	input  logic            rst,
	pe_ctrl_if.pe           ctl,
	mem_rd_if.client        rd,
	input  mxv_pkg::data_t  vec [mxv_pkg::N]
);

	import mxv_pkg::*;

	idx_t col;                                  // Current column
	acc_t acc;                                  // Running dot product
	acc_t product;
	logic req_q;                                // Waiting for a grant
	logic pend;                                 // Granted, data arrives now
	logic done_q;

	assign rd.req     = req_q;
	assign rd.addr    = {ROW, col};             // ROW * N + col
	assign ctl.done   = done_q;
	assign ctl.result = acc;

	assign product = acc_t'(rd.rdata) * acc_t'(vec[col]);

	// ============================================================
	// Row walk
	// ============================================================
	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			col    <= '0;
			acc    <= '0;
			req_q  <= 1'b0;
			pend   <= 1'b0;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			if (ctl.start)
			begin
				acc   <= '0;                    // Fresh row, no carry-in
				col   <= '0;
				req_q <= 1'b1;
				pend  <= 1'b0;
			end
			else
			begin
				if (req_q && rd.gnt)
				begin
					req_q <= 1'b0;              // Addr accepted by bank
					pend  <= 1'b1;
				end
				if (pend)
				begin
					acc  <= acc + product;
					pend <= 1'b0;
					if (col == idx_t'(N - 1))
						done_q <= 1'b1;         // Result valid with this pulse
					else
					begin
						col   <= col + 1'b1;
						req_q <= 1'b1;          // Next element
					end
				end
			end
		end
	end

endmodule

//--- hw/matrix_bank.sv
// Matrix store of N*N elements, written from APB
// Single read port shared by the PEs through a round-robin arbiter

`timescale 1ns/1ps

module matrix_bank
(
	input  logic                clk,
	input  logic                rst,
	input  logic                mat_we,
	input  mxv_pkg::mat_addr_t  mat_waddr,
	input  mxv_pkg::data_t      mat_wdata,
	mem_rd_if.bank              clients [mxv_pkg::N]
);

	import mxv_pkg::*;

	data_t     mem [N*N];                       // Row-major storage
	logic      [N-1:0] req_v;
	logic      [N-1:0] gnt_v;
	mat_addr_t addr_v [N];
	idx_t      ptr;                             // First client searched this cycle
	idx_t      sel;                             // Granted client
	logic      found;
	data_t     rdata_q;                         // Shared read data register

	for (genvar i = 0; i < N; i++)
	begin : g_client
		assign req_v[i]         = clients[i].req;
		assign addr_v[i]        = clients[i].addr;
		assign clients[i].gnt   = gnt_v[i];
		assign clients[i].rdata = rdata_q;      // Only the granted one samples it
	end

	// ============================================================
	// Round-robin arbiter
	// ============================================================
	always_comb
	begin : arb
		idx_t cand;
		found = 1'b0;
		sel   = ptr;
		gnt_v = '0;
		for (int k = 0; k < N; k++)
		begin
			cand = ptr + idx_t'(k);             // Wraps modulo N
			if (!found && req_v[cand])
			begin
				found = 1'b1;
				sel   = cand;
			end
		end
		if (found)
			gnt_v[sel] = 1'b1;
	end : arb

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			ptr <= '0;                          // PE 0 has first priority
		else if (found)
			ptr <= sel + 1'b1;                  // Search after last winner
	end

	// ============================================================
	// Storage
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (mat_we)
			mem[mat_waddr] <= mat_wdata;        // Only while controller idle
		if (found)
			rdata_q <= mem[addr_v[sel]];
	end

endmodule

//--- hw/mxv_top.sv
// Top level of the matrix-vector multiplier
// APB register block, run controller, four row PEs and the shared matrix bank

`timescale 1ns/1ps

module mxv_top
(
	input  logic                clk,
	input  logic                rst,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  mxv_pkg::apb_addr_t  paddr,
	input  logic [31:0]         pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr,
	output logic                irq
);

	import mxv_pkg::*;

	logic      busy;
	logic      done_flag;
	logic      run_start;
	logic      [N-1:0] res_valid;
	data_t     vec [N];                         // Broadcast vector
	acc_t      res [N];                         // One result per row
	logic      mat_we;
	mat_addr_t mat_waddr;
	data_t     mat_wdata;

	pe_ctrl_if pc [N] ();
	mem_rd_if  mr [N] ();

	assign irq = done_flag;                     // Level, cleared by next start

	mxv_apb_regs u_regs
	(
		.clk       (clk),
		.rst       (rst),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.busy      (busy),
		.done_flag (done_flag),
		.run_start (run_start),
		.vec       (vec),
		.res       (res),
		.res_valid (res_valid),
		.mat_we    (mat_we),
		.mat_waddr (mat_waddr),
		.mat_wdata (mat_wdata)
	);

	mxv_ctrl u_ctrl
	(
		.clk       (clk),
		.rst       (rst),
		.run_start (run_start),
		.busy      (busy),
		.done_flag (done_flag),
		.res_valid (res_valid),
		.pe        (pc)
	);

	// One PE per matrix row
	for (genvar i = 0; i < N; i++)
	begin : g_pe
		assign res[i] = pc[i].result;

		mxv_pe #(.ROW(idx_t'(i))) u_pe
		(
			.clk (clk),
			.rst (rst),
			.ctl (pc[i]),
			.rd  (mr[i]),
			.vec (vec)
		);
	end

	matrix_bank u_bank
	(
		.clk       (clk),
		.rst       (rst),
		.mat_we    (mat_we),
		.mat_waddr (mat_waddr),
		.mat_wdata (mat_wdata),
		.clients   (mr)
	);

endmodule

//--- testbench/mxv_asserts.sv
// Arbiter checks for the matrix bank, bound into matrix_bank
// One-hot grants, grants only to requesters, bounded wait per client

`timescale 1ns/1ps

module mxv_asserts
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic [mxv_pkg::N-1:0]  req,
	input  logic [mxv_pkg::N-1:0]  gnt
);

	import mxv_pkg::*;

	int wait_cnt [N];                           // Cycles a client has waited so far

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 0; i < N; i++)
				wait_cnt[i] <= 0;
		end
		else
		begin
			for (int i = 0; i < N; i++)
				if (req[i] && !gnt[i])
					wait_cnt[i] <= wait_cnt[i] + 1;   // Still stalled
				else
					wait_cnt[i] <= 0;
		end
	end

	// ============================================================
	// Grant properties
	// ============================================================
	gnt_onehot: assert property (@(posedge clk) disable iff (!rst) $onehot0(gnt))
		else $error("arbiter granted several clients at once, gnt=%b", gnt);

	gnt_has_req: assert property (@(posedge clk) disable iff (!rst) (gnt & ~req) == '0)
		else $error("grant to a client that is not requesting, gnt=%b req=%b", gnt, req);

	for (genvar i = 0; i < N; i++)
	begin : g_wait
		wait_bound: assert property (@(posedge clk) disable iff (!rst) wait_cnt[i] < N)
			else $error("client %0d not granted within %0d cycles", i, N);
	end

endmodule

bind matrix_bank mxv_asserts u_asserts
(
	.clk (clk),
	.rst (rst),
	.req (req_v),
	.gnt (gnt_v)
);

//--- testbench/mxv_tb.sv
// Testbench for the matrix-vector multiplier
// APB driver tasks, software reference model, directed tests and watchdog

`timescale 1ns/1ps

module mxv_tb;

	import mxv_pkg::*;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 10;
	localparam int RUN_LIMIT    = 40;           // Worst case from start write to irq
	localparam int RUNS         = 8;            // Runs over all tests
	localparam int APB_CYCLES   = 64;           // About 32 accesses per run
	localparam int WATCHDOG_NS  = (RESET_CYCLES + RUNS * (RUN_LIMIT + APB_CYCLES))
	                              * CLK_PERIOD * 2;   // Double for margin

	logic        clk;
	logic        rst;
	logic        psel;
	logic        penable;
	logic        pwrite;
	apb_addr_t   paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        irq;

	int    errors = 0;
	int    checks = 0;
	int    seed   = 62;
	data_t mat_m [N*N];                         // Model copy of the matrix
	data_t vec_m [N];                           // Model copy of the vector

	mxv_top dut_i
	(
		.clk     (clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.irq     (irq)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ============================================================
	// Compare tasks
	// ============================================================
	task automatic check_acc(input string name, input acc_t exp, input acc_t act);
		checks++;
		if (exp !== act)
		begin
			$display("FAILED t=%0t %s expected %0d got %0d", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		checks++;
		if (exp !== act)
		begin
			$display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act)
		begin
			$display("FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
			errors++;
		end
	endtask

	// ============================================================
	// APB driver tasks called 1 ns after a rising edge
	// ============================================================
	task automatic apb_write(input apb_addr_t addr, input logic [31:0] data, output logic err);
		psel    = 1'b1;                         // Setup phase
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#1 penable = 1'b1;                      // Access phase
		#1 err = pslverr;                       // Sampled mid-cycle
		check_bit("pready", 1'b1, pready);
		@(posedge clk);
		#1 psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output logic [31:0] data, output logic err);
		psel   = 1'b1;
		pwrite = 1'b0;
		paddr  = addr;
		@(posedge clk);
		#1 penable = 1'b1;
		#1 data = prdata;
		err = pslverr;
		check_bit("pready", 1'b1, pready);
		@(posedge clk);
		#1 psel = 1'b0;
		penable = 1'b0;
	endtask

	// Sum over columns of matrix times vector
	function automatic acc_t ref_row(input int r);
		int sum;
		sum = 0;
		for (int c = 0; c < N; c++)
			sum += int'(mat_m[r*N + c]) * int'(vec_m[c]);
		return acc_t'(sum);
	endfunction

	task automatic load_data();
		logic err;
		for (int k = 0; k < N*N; k++)
		begin
			apb_write(apb_addr_t'(ADDR_MAT + 4*k), 32'(mat_m[k]), err);
			check_bit("pslverr on matrix write", 1'b0, err);
		end
		for (int c = 0; c < N; c++)
		begin
			apb_write(apb_addr_t'(ADDR_VEC + 4*c), 32'(vec_m[c]), err);
			check_bit("pslverr on vector write", 1'b0, err);
		end
	endtask

	task automatic randomize_data();
		for (int k = 0; k < N*N; k++)
			mat_m[k] = data_t'($random(seed));
		for (int c = 0; c < N; c++)
			vec_m[c] = data_t'($random(seed));
	endtask

	task automatic start_run();
		logic err;
		apb_write(ADDR_CTRL, 32'h1, err);
		check_bit("pslverr on start", 1'b0, err);
	endtask

	// Poll irq each cycle up to the worst-case run length
	task automatic wait_done();
		int cyc;
		cyc = 0;
		do
		begin
			@(posedge clk);
			#1 cyc++;
		end
		while (!irq && cyc < RUN_LIMIT);
		if (!irq)
		begin
			$display("ERROR t=%0t irq did not rise within %0d cycles", $time, RUN_LIMIT);
			errors++;
		end
	endtask

	task automatic check_results();
		logic [31:0] rd;
		logic        err;
		for (int r = 0; r < N; r++)
		begin
			apb_read(apb_addr_t'(ADDR_RES + 4*r), rd, err);
			check_acc($sformatf("res[%0d]", r), ref_row(r), acc_t'(rd));
		end
	endtask

	// ============================================================
	// Directed tests
	// ============================================================
	task automatic test_reset_state();
		logic [31:0] rd;
		logic        err;
		apb_read(ADDR_STATUS, rd, err);
		check_bit("status.busy", 1'b0, rd[0]);
		check_bit("status.done", 1'b0, rd[1]);
		check_bit("irq", 1'b0, irq);
		for (int r = 0; r < N; r++)
		begin
			apb_read(apb_addr_t'(ADDR_RES + 4*r), rd, err);
			check_acc($sformatf("res[%0d] after reset", r), '0, acc_t'(rd));
		end
	endtask

	task automatic test_identity();
		logic [31:0] rd;
		logic        err;
		randomize_data();
		for (int k = 0; k < N*N; k++)
			mat_m[k] = (k / N == k % N) ? 8'd1 : 8'd0;    // Ones on the diagonal
		load_data();
		for (int c = 0; c < N; c++)
		begin
			apb_read(apb_addr_t'(ADDR_VEC + 4*c), rd, err);
			check_data($sformatf("vec[%0d]", c), vec_m[c], data_t'(rd));
		end
		start_run();
		wait_done();
		for (int r = 0; r < N; r++)
		begin
			apb_read(apb_addr_t'(ADDR_RES + 4*r), rd, err);
			check_acc($sformatf("res[%0d] identity", r), acc_t'(vec_m[r]), acc_t'(rd));
		end
	endtask

	task automatic test_random();
		for (int t = 0; t < 5; t++)
		begin
			randomize_data();
			if (t == 4)
			begin
				mat_m = '{default: 8'hFF};      // Largest sums
				vec_m = '{default: 8'hFF};
			end
			load_data();
			start_run();
			wait_done();
			check_results();
		end
	endtask

	task automatic test_busy_writes();
		logic err;
		randomize_data();
		load_data();
		start_run();
		apb_write(apb_addr_t'(ADDR_MAT + 4*5), 32'h5A, err);
		check_bit("pslverr on busy matrix write", 1'b1, err);
		apb_write(ADDR_VEC, 32'hA5, err);
		check_bit("pslverr on busy vector write", 1'b1, err);
		wait_done();
		check_results();                        // Original data still in use
	endtask

	task automatic test_unmapped();
		logic [31:0] rd;
		logic        err;
		apb_write(8'h24, 32'h1234, err);
		check_bit("pslverr on unmapped write", 1'b1, err);
		apb_read(8'hC0, rd, err);
		check_bit("pslverr on unmapped read", 1'b1, err);
		checks++;
		if (rd !== 32'h0)
		begin
			$display("FAILED t=%0t prdata expected 00000000 got %h", $time, rd);
			errors++;
		end
	endtask

	task automatic test_irq();
		logic [31:0] rd;
		logic        err;
		check_bit("irq after run", 1'b1, irq);
		repeat (5) @(posedge clk);
		#1 check_bit("irq held", 1'b1, irq);
		start_run();
		apb_read(ADDR_STATUS, rd, err);
		check_bit("status.busy after start", 1'b1, rd[0]);
		check_bit("irq after start", 1'b0, irq);
		wait_done();
		check_bit("irq at end of run", 1'b1, irq);
		check_results();
	endtask

	// ============================================================
	// Main sequence and watchdog
	// ============================================================
	initial
	begin
		clk     = 1'b0;
		rst     = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst = 1'b1;
		test_reset_state();
		test_identity();
		test_random();
		test_busy_writes();
		test_unmapped();
		test_irq();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, %0d checks, %0d errors",
		         WATCHDOG_NS, checks, errors);
		$display("sim failed");
		$finish;
	end

endmodule

//--- sources.f
hw/mxv_pkg.sv
hw/pe_if.sv
hw/mxv_apb_regs.sv
hw/mxv_ctrl.sv
hw/mxv_pe.sv
hw/matrix_bank.sv
hw/mxv_top.sv
testbench/mxv_asserts.sv
testbench/mxv_tb.sv

//--- Makefile
# Verilator lint and simulation of the matrix-vector multiplier
TOP = mxv_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
